// ==== design/pc_io_pkg.sv ====
`default_nettype none

package pc_io_pkg;

	localparam int unsigned PORT_W = 16;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned BYTE_W = 8;
	localparam int unsigned SIZE_W = 3;

	typedef logic [PORT_W-1:0] port_addr_t;
	typedef logic [DATA_W-1:0] io_data_t;
	typedef logic [BYTE_W-1:0] io_byte_t;
	typedef logic [SIZE_W-1:0] io_size_t;
	typedef logic [BYTE_W-1:0] sysctl_val_t;

	// legacy port map, base and count of ignored low bits
	localparam port_addr_t PORT_HDD0       = 16'h01F0;
	localparam int unsigned MASKW_HDD0     = 3;
	localparam port_addr_t PORT_HDD0_ALT   = 16'h03F6;
	localparam int unsigned MASKW_HDD0_ALT = 0;
	localparam port_addr_t PORT_HDD1       = 16'h0170;
	localparam int unsigned MASKW_HDD1     = 3;
	localparam port_addr_t PORT_HDD1_ALT   = 16'h0376;
	localparam int unsigned MASKW_HDD1_ALT = 0;
	localparam port_addr_t PORT_FLOPPY     = 16'h03F0;
	localparam int unsigned MASKW_FLOPPY   = 3;
	localparam port_addr_t PORT_JOY        = 16'h0201;
	localparam int unsigned MASKW_JOY      = 0;
	localparam port_addr_t PORT_DMA_MASTER = 16'h00C0;
	localparam int unsigned MASKW_DMA_MASTER = 5;
	localparam port_addr_t PORT_DMA_PAGE   = 16'h0080;
	localparam int unsigned MASKW_DMA_PAGE = 4;
	localparam port_addr_t PORT_DMA_SLAVE  = 16'h0000;
	localparam int unsigned MASKW_DMA_SLAVE = 4;
	localparam port_addr_t PORT_PIC_MASTER = 16'h0020;
	localparam int unsigned MASKW_PIC_MASTER = 1;
	localparam port_addr_t PORT_PIC_SLAVE  = 16'h00A0;
	localparam int unsigned MASKW_PIC_SLAVE = 1;
	localparam port_addr_t PORT_PIT        = 16'h0040;
	localparam int unsigned MASKW_PIT      = 2;
	localparam port_addr_t PORT_PIT_SPK    = 16'h0061; // speaker gate, shared with ps2 range
	localparam int unsigned MASKW_PIT_SPK  = 0;
	localparam port_addr_t PORT_PS2_IO     = 16'h0060;
	localparam int unsigned MASKW_PS2_IO   = 3;
	localparam port_addr_t PORT_PS2_CTL    = 16'h0090;
	localparam int unsigned MASKW_PS2_CTL  = 4;
	localparam port_addr_t PORT_RTC        = 16'h0070;
	localparam int unsigned MASKW_RTC      = 1;
	localparam port_addr_t PORT_FM         = 16'h0388;
	localparam int unsigned MASKW_FM       = 2;
	localparam port_addr_t PORT_SB         = 16'h0220;
	localparam int unsigned MASKW_SB       = 4;
	localparam port_addr_t PORT_UART       = 16'h03F8;
	localparam int unsigned MASKW_UART     = 3;
	localparam port_addr_t PORT_MPU        = 16'h0330;
	localparam int unsigned MASKW_MPU      = 1;
	localparam port_addr_t PORT_VGA_B      = 16'h03B0;
	localparam int unsigned MASKW_VGA_B    = 4;
	localparam port_addr_t PORT_VGA_C      = 16'h03C0;
	localparam int unsigned MASKW_VGA_C    = 4;
	localparam port_addr_t PORT_VGA_D      = 16'h03D0;
	localparam int unsigned MASKW_VGA_D    = 4;
	localparam port_addr_t PORT_SYSCTL     = 16'h8888;
	localparam int unsigned MASKW_SYSCTL   = 0;

	localparam sysctl_val_t SYSCTL_RESET   = 8'hA2;
	localparam io_byte_t    SYSCTL_KEY     = 8'hA1; // must sit in bits 15:8
	localparam io_size_t    SYSCTL_WR_SIZE = 3'd2;
	localparam io_byte_t    OPEN_BUS_BYTE  = 8'hFF;

	typedef struct packed {
		logic hdd0;
		logic hdd1;
		logic floppy;
		logic joy;
		logic dma_master;
		logic dma_page;
		logic dma_slave;
		logic pic_master;
		logic pic_slave;
		logic pit;
		logic ps2_io;
		logic ps2_ctl;
		logic rtc;
		logic fm;
		logic sb;
		logic uart;
		logic mpu;
		logic vga_b;
		logic vga_c;
		logic vga_d;
		logic sysctl;
	} dev_sel_t;

	typedef struct packed {
		io_byte_t floppy;
		io_byte_t dma;
		io_byte_t pic;
		io_byte_t pit;
		io_byte_t ps2;
		io_byte_t rtc;
		io_byte_t sound;
		io_byte_t uart;
		io_byte_t vga;
		io_byte_t joy;
		io_data_t hdd0;
		io_data_t hdd1;
	} dev_rdata_t;

	typedef struct packed {
		port_addr_t addr;
		io_size_t   size;
		io_data_t   wdata;
		logic       write;
	} io_req_t;

	typedef enum logic [2:0] {
		IDLE,
		DECODE,
		STROBE,
		CAPTURE,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

// ==== design/io_port_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  pc_io_pkg::port_addr_t addr,
	output pc_io_pkg::dev_sel_t   sel
);

	pc_io_pkg::dev_sel_t sel_next;

	// match with the low mw bits ignored
	function automatic logic hit(
		input pc_io_pkg::port_addr_t a,
		input pc_io_pkg::port_addr_t base,
		input int unsigned           mw
	);
		return (a >> mw) == (base >> mw);
	endfunction

	always_comb begin
		sel_next = '0;
		sel_next.hdd0       = hit(addr, pc_io_pkg::PORT_HDD0, pc_io_pkg::MASKW_HDD0) ||
			hit(addr, pc_io_pkg::PORT_HDD0_ALT, pc_io_pkg::MASKW_HDD0_ALT);
		sel_next.hdd1       = hit(addr, pc_io_pkg::PORT_HDD1, pc_io_pkg::MASKW_HDD1) ||
			hit(addr, pc_io_pkg::PORT_HDD1_ALT, pc_io_pkg::MASKW_HDD1_ALT);
		sel_next.floppy     = hit(addr, pc_io_pkg::PORT_FLOPPY, pc_io_pkg::MASKW_FLOPPY);
		sel_next.joy        = hit(addr, pc_io_pkg::PORT_JOY, pc_io_pkg::MASKW_JOY);
		sel_next.dma_master = hit(addr, pc_io_pkg::PORT_DMA_MASTER,
			pc_io_pkg::MASKW_DMA_MASTER);
		sel_next.dma_page   = hit(addr, pc_io_pkg::PORT_DMA_PAGE, pc_io_pkg::MASKW_DMA_PAGE);
		sel_next.dma_slave  = hit(addr, pc_io_pkg::PORT_DMA_SLAVE, pc_io_pkg::MASKW_DMA_SLAVE);
		sel_next.pic_master = hit(addr, pc_io_pkg::PORT_PIC_MASTER,
			pc_io_pkg::MASKW_PIC_MASTER);
		sel_next.pic_slave  = hit(addr, pc_io_pkg::PORT_PIC_SLAVE, pc_io_pkg::MASKW_PIC_SLAVE);
		sel_next.pit        = hit(addr, pc_io_pkg::PORT_PIT, pc_io_pkg::MASKW_PIT) ||
			hit(addr, pc_io_pkg::PORT_PIT_SPK, pc_io_pkg::MASKW_PIT_SPK);
		sel_next.ps2_io     = hit(addr, pc_io_pkg::PORT_PS2_IO, pc_io_pkg::MASKW_PS2_IO);
		sel_next.ps2_ctl    = hit(addr, pc_io_pkg::PORT_PS2_CTL, pc_io_pkg::MASKW_PS2_CTL);
		sel_next.rtc        = hit(addr, pc_io_pkg::PORT_RTC, pc_io_pkg::MASKW_RTC);
		sel_next.fm         = hit(addr, pc_io_pkg::PORT_FM, pc_io_pkg::MASKW_FM);
		sel_next.sb         = hit(addr, pc_io_pkg::PORT_SB, pc_io_pkg::MASKW_SB);
		sel_next.uart       = hit(addr, pc_io_pkg::PORT_UART, pc_io_pkg::MASKW_UART);
		sel_next.mpu        = hit(addr, pc_io_pkg::PORT_MPU, pc_io_pkg::MASKW_MPU);
		sel_next.vga_b      = hit(addr, pc_io_pkg::PORT_VGA_B, pc_io_pkg::MASKW_VGA_B);
		sel_next.vga_c      = hit(addr, pc_io_pkg::PORT_VGA_C, pc_io_pkg::MASKW_VGA_C);
		sel_next.vga_d      = hit(addr, pc_io_pkg::PORT_VGA_D, pc_io_pkg::MASKW_VGA_D);
		sel_next.sysctl     = hit(addr, pc_io_pkg::PORT_SYSCTL, pc_io_pkg::MASKW_SYSCTL);
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			sel <= '0;
		else
			sel <= sel_next; // one edge after the address latch
	end

	a_sel_clear_after_reset: assert property (
		@(posedge clk_sys) reset |=> sel == '0
	);

endmodule

`default_nettype wire

// ==== design/io_cycle_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_cycle_sequencer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_do,
	input  pc_io_pkg::io_req_t    io_req,
	output logic                  io_busy,
	output logic                  io_done,
	output pc_io_pkg::port_addr_t bus_addr,
	output pc_io_pkg::io_data_t   bus_wdata,
	output pc_io_pkg::io_size_t   bus_size,
	output logic                  bus_read,
	output logic                  bus_write,
	output logic                  capture
);

	pc_io_pkg::seq_state_t state;
	pc_io_pkg::seq_state_t state_next;
	pc_io_pkg::io_req_t    req_q;
	logic                  accept;

	assign accept = state == pc_io_pkg::IDLE && io_do; // do while busy is dropped

	always_comb begin
		state_next = state;
		case (state)
			pc_io_pkg::IDLE: begin
				if (io_do)
					state_next = pc_io_pkg::DECODE;
			end
			pc_io_pkg::DECODE:  state_next = pc_io_pkg::STROBE; // decoder registers sel
			pc_io_pkg::STROBE:  state_next = pc_io_pkg::CAPTURE;
			pc_io_pkg::CAPTURE: state_next = pc_io_pkg::DONE;
			pc_io_pkg::DONE:    state_next = pc_io_pkg::IDLE;
			default:            state_next = pc_io_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			state <= pc_io_pkg::IDLE;
		else
			state <= state_next;
	end

	// request held stable for the whole cycle
	always_ff @(posedge clk_sys) begin
		if (accept)
			req_q <= io_req;
	end

	assign bus_addr  = req_q.addr;
	assign bus_wdata = req_q.wdata;
	assign bus_size  = req_q.size;

	assign bus_read  = state == pc_io_pkg::STROBE && !req_q.write;
	assign bus_write = state == pc_io_pkg::STROBE && req_q.write;
	assign capture   = state == pc_io_pkg::CAPTURE;

	assign io_busy = state != pc_io_pkg::IDLE;
	assign io_done = state == pc_io_pkg::DONE; // readback already registered

	a_strobe_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(bus_read && bus_write)
	);

	// done only four edges after an accepted do
	a_done_latency: assert property (
		@(posedge clk_sys) disable iff (reset)
		io_done |-> $past(accept, 4)
	);

endmodule

`default_nettype wire

// ==== design/io_readback_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_readback_select (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pc_io_pkg::dev_sel_t    sel,
	input  pc_io_pkg::dev_rdata_t  rdata,
	input  logic                   capture,
	output pc_io_pkg::io_data_t    io_rdata
);

	pc_io_pkg::io_byte_t byte_pick;
	pc_io_pkg::io_data_t word_pick;

	// 8-bit groups, first match wins
	always_comb begin
		if (sel.floppy)
			byte_pick = rdata.floppy;
		else if (sel.dma_master || sel.dma_slave || sel.dma_page)
			byte_pick = rdata.dma;
		else if (sel.pic_master || sel.pic_slave)
			byte_pick = rdata.pic;
		else if (sel.pit)
			byte_pick = rdata.pit;
		else if (sel.ps2_io || sel.ps2_ctl)
			byte_pick = rdata.ps2;
		else if (sel.rtc)
			byte_pick = rdata.rtc;
		else if (sel.sb || sel.fm)
			byte_pick = rdata.sound;
		else if (sel.uart || sel.mpu)
			byte_pick = rdata.uart;
		else if (sel.vga_b || sel.vga_c || sel.vga_d)
			byte_pick = rdata.vga;
		else if (sel.joy)
			byte_pick = rdata.joy;
		else
			byte_pick = pc_io_pkg::OPEN_BUS_BYTE; // nobody answered
	end

	// disk words ahead of every byte device
	always_comb begin
		if (sel.hdd0)
			word_pick = rdata.hdd0;
		else if (sel.hdd1)
			word_pick = rdata.hdd1;
		else
			word_pick = {24'd0, byte_pick};
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_rdata <= '0;
		else if (capture)
			io_rdata <= word_pick;
	end

endmodule

`default_nettype wire

// ==== design/sysctl_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysctl_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pc_io_pkg::dev_sel_t    sel,
	input  logic                   bus_write,
	input  logic                   bus_read,
	input  pc_io_pkg::io_size_t    bus_size,
	input  pc_io_pkg::io_data_t    bus_wdata,
	output pc_io_pkg::sysctl_val_t syscfg
);

	logic in_reset;
	logic boot_access;
	logic key_write;

	// first disk or floppy access means the BIOS is running
	assign boot_access = (bus_read || bus_write) && (sel.hdd0 || sel.hdd1 || sel.floppy);

	assign key_write = bus_write && sel.sysctl &&
		bus_size == pc_io_pkg::SYSCTL_WR_SIZE &&
		bus_wdata[15:8] == pc_io_pkg::SYSCTL_KEY;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg   <= pc_io_pkg::SYSCTL_RESET;
			in_reset <= 1'b1;
		end else if (boot_access && in_reset) begin
			syscfg   <= '0;
			in_reset <= 1'b0;
		end else if (key_write) begin
			syscfg   <= bus_wdata[7:0]; // low byte is the new config
			in_reset <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/pc_io_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_io_hub (
	input  logic                   clk_sys,
	input  logic                   reset,

	input  logic                   io_do,
	input  pc_io_pkg::io_req_t     io_req,
	output logic                   io_busy,
	output logic                   io_done,
	output pc_io_pkg::io_data_t    io_rdata,

	output pc_io_pkg::port_addr_t  bus_addr,
	output pc_io_pkg::io_data_t    bus_wdata,
	output pc_io_pkg::io_size_t    bus_size,
	output logic                   bus_read,
	output logic                   bus_write,
	output pc_io_pkg::dev_sel_t    dev_sel,
	input  pc_io_pkg::dev_rdata_t  dev_rdata,

	output pc_io_pkg::sysctl_val_t syscfg
);

	logic capture;

	io_cycle_sequencer seq0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_do     (io_do),
		.io_req    (io_req),
		.io_busy   (io_busy),
		.io_done   (io_done),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_size  (bus_size),
		.bus_read  (bus_read),
		.bus_write (bus_write),
		.capture   (capture)
	);

	io_port_decoder dec0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.addr    (bus_addr),
		.sel     (dev_sel)
	);

	io_readback_select rbk0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.sel      (dev_sel),
		.rdata    (dev_rdata),
		.capture  (capture),
		.io_rdata (io_rdata)
	);

	// config byte rides on the same strobes as the devices
	sysctl_port ctl0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sel       (dev_sel),
		.bus_write (bus_write),
		.bus_read  (bus_read),
		.bus_size  (bus_size),
		.bus_wdata (bus_wdata),
		.syscfg    (syscfg)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_pc_io_tasks.svh ====
`ifndef TB_PC_IO_TASKS_SVH
`define TB_PC_IO_TASKS_SVH

// group id in the high nibble, port low nibble below
function automatic pc_io_pkg::io_byte_t group_byte(input logic [3:0] id,
	input pc_io_pkg::port_addr_t addr);
	return {id, addr[3:0]};
endfunction

function automatic pc_io_pkg::io_data_t hdd_word(input logic [7:0] tag,
	input pc_io_pkg::port_addr_t addr);
	return {tag, tag, addr};
endfunction

task automatic report_mismatch(input string msg);
	$display("Mismatch at %0t ns: %s", $time, msg);
	$display("TESTBENCH FAILED");
	$fatal(1, "value check failed");
endtask

task automatic report_timeout(input string msg);
	$display("Timed out at %0t ns waiting for %s", $time, msg);
	$display("TESTBENCH FAILED");
	$fatal(1, "timeout");
endtask

task automatic check_word(input string what, input pc_io_pkg::io_data_t got,
	input pc_io_pkg::io_data_t exp);
	assert (got === exp)
	else report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
endtask

// busy and bus strobes in one cycle of a request
task automatic check_bus(input pc_io_pkg::io_req_t req, input bit strobe_cycle);
	assert (io_busy || io_done)
	else report_mismatch($sformatf("io_busy low before done, port %h", req.addr));
	if (strobe_cycle) begin
		assert (bus_read === !req.write && bus_write === req.write)
		else report_mismatch($sformatf("strobe read %b write %b for port %h", bus_read,
			bus_write, req.addr));
		check_word("bus_addr in strobe cycle", 32'(bus_addr), 32'(req.addr));
		check_word("bus_size in strobe cycle", 32'(bus_size), 32'(req.size));
		check_word("bus_wdata in strobe cycle", bus_wdata, req.wdata);
	end else begin
		assert (!bus_read && !bus_write)
		else report_mismatch($sformatf("strobe outside its cycle, port %h", req.addr));
	end
endtask

// one CPU request, returns read data and edges until done is seen
task automatic run_cycle(input pc_io_pkg::io_req_t req, output pc_io_pkg::io_data_t rdata,
	output int edges);
	int  n;
	bit  seen;
	n    = 0;
	seen = 0;
	@(posedge clk_sys);
	io_do  <= 1'b1;
	io_req <= req;
	while (!seen && n < TIMEOUT_CYCLES) begin
		@(posedge clk_sys);
		io_do <= 1'b0;
		n++;
		@(negedge clk_sys);
		check_bus(req, n == STROBE_EDGE);
		if (io_done)
			seen = 1;
	end
	if (!seen)
		report_timeout($sformatf("io_done for port %h", req.addr));
	rdata = io_rdata;
	edges = n;
endtask

task automatic io_read(input pc_io_pkg::port_addr_t addr, input pc_io_pkg::io_data_t exp);
	pc_io_pkg::io_req_t  req;
	pc_io_pkg::io_data_t rdata;
	int                  edges;
	req       = '0;
	req.addr  = addr;
	req.size  = 3'd1;
	run_cycle(req, rdata, edges);
	check_word($sformatf("read port %h", addr), rdata, exp);
endtask

task automatic io_write(input pc_io_pkg::port_addr_t addr, input pc_io_pkg::io_size_t size,
	input pc_io_pkg::io_data_t data);
	pc_io_pkg::io_req_t  req;
	pc_io_pkg::io_data_t rdata;
	int                  edges;
	req       = '0;
	req.addr  = addr;
	req.size  = size;
	req.wdata = data;
	req.write = 1'b1;
	run_cycle(req, rdata, edges);
endtask

task automatic check_reset_state();
	@(negedge clk_sys);
	check_word("dev_sel after reset", 32'(dev_sel), 32'd0); // decode follows bus_addr later
	repeat (5) begin
		assert (!bus_read && !bus_write && !io_done && !io_busy)
		else report_mismatch("strobe, done or busy seen after reset");
		check_word("syscfg after reset", 32'(syscfg), 32'h0000_00A2);
		@(negedge clk_sys);
	end
endtask

task automatic test_sysctl();
	io_write(16'h8888, 3'd2, 32'h0000_125C); // no key, still in reset state
	check_word("syscfg after keyless write", 32'(syscfg), 32'h0000_00A2);
	io_read(16'h03F0, {24'd0, group_byte(4'h1, 16'h03F0)});
	check_word("syscfg after first floppy access", 32'(syscfg), 32'd0);
	io_write(16'h8888, 3'd2, 32'h0000_A15C);
	check_word("syscfg after keyed write", 32'(syscfg), 32'h0000_005C);
	io_write(16'h8888, 3'd2, 32'h0000_1277);
	check_word("syscfg after bad key", 32'(syscfg), 32'h0000_005C);
	io_write(16'h8888, 3'd1, 32'h0000_A17E); // wrong size
	check_word("syscfg after byte write", 32'(syscfg), 32'h0000_005C);
endtask

task automatic test_device_reads();
	pc_io_pkg::port_addr_t ports[20] = '{16'h03F2, 16'h0000, 16'h0085, 16'h00C4,
		16'h0021, 16'h00A1, 16'h0040, 16'h0061, 16'h0064, 16'h0092, 16'h0071,
		16'h0388, 16'h0220, 16'h03F8, 16'h0330, 16'h03B4, 16'h03C5, 16'h03D4,
		16'h0201, 16'h0023};
	logic [3:0] ids[20] = '{4'h1, 4'h2, 4'h2, 4'h2, 4'h3, 4'h3, 4'h4, 4'h4, 4'h5,
		4'h5, 4'h6, 4'h7, 4'h7, 4'h8, 4'h8, 4'h9, 4'h9, 4'h9, 4'hA, 4'h0};
	// last entry falls between pic and pit, open bus
	for (int i = 0; i < 19; i++)
		io_read(ports[i], {24'd0, group_byte(ids[i], ports[i])});
	io_read(ports[19], 32'h0000_00FF);
	io_read(16'h01F0, hdd_word(8'hD0, 16'h01F0));
	io_read(16'h03F6, hdd_word(8'hD0, 16'h03F6)); // disk status beats floppy
	io_read(16'h0177, hdd_word(8'hD1, 16'h0177));
	io_read(16'h0376, hdd_word(8'hD1, 16'h0376));
endtask

task automatic test_open_bus();
	pc_io_pkg::port_addr_t addr;
	io_read(16'h0300, 32'h0000_00FF);
	io_read(16'h0400, 32'h0000_00FF);
	io_read(16'h8889, 32'h0000_00FF);
	repeat (8) begin
		addr = 16'h1000 | (16'($random(seed)) & 16'h6FFF); // 1000 to 7FFF is unmapped
		io_read(addr, 32'h0000_00FF);
	end
endtask

task automatic test_timing();
	pc_io_pkg::io_req_t  req;
	pc_io_pkg::io_data_t rdata;
	int                  edges;
	int                  n;
	int                  dones;
	bit                  seen;
	req      = '0;
	req.addr = 16'h0040;
	req.size = 3'd1;
	run_cycle(req, rdata, edges);
	assert (edges == EXPECTED_LATENCY)
	else report_mismatch($sformatf("done after %0d edges, expected %0d", edges,
		EXPECTED_LATENCY));

	// second do lands while busy
	@(posedge clk_sys);
	io_do  <= 1'b1;
	io_req <= req;
	@(posedge clk_sys);
	io_req.addr <= 16'h0071;
	@(posedge clk_sys);
	io_do <= 1'b0;
	n     = 0;
	seen  = 0;
	while (!seen && n < TIMEOUT_CYCLES) begin
		@(negedge clk_sys);
		if (io_done)
			seen = 1;
		n++;
	end
	if (!seen)
		report_timeout("io_done of the busy test");
	check_word("read during busy test", io_rdata, {24'd0, group_byte(4'h4, 16'h0040)});
	dones = 0;
	repeat (12) begin
		@(negedge clk_sys);
		if (io_done)
			dones++;
	end
	assert (dones == 0)
	else report_mismatch($sformatf("%0d extra done pulses after ignored do", dones));
endtask

`endif

// ==== testbench/tb_pc_io_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pc_io_hub;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int EXPECTED_LATENCY = 4;
	localparam int STROBE_EDGE = 2;

	logic                   clk_sys;
	logic                   reset;
	logic                   io_do;
	pc_io_pkg::io_req_t     io_req;
	logic                   io_busy;
	logic                   io_done;
	pc_io_pkg::io_data_t    io_rdata;
	pc_io_pkg::port_addr_t  bus_addr;
	pc_io_pkg::io_data_t    bus_wdata;
	pc_io_pkg::io_size_t    bus_size;
	logic                   bus_read;
	logic                   bus_write;
	pc_io_pkg::dev_sel_t    dev_sel;
	pc_io_pkg::dev_rdata_t  dev_rdata;
	pc_io_pkg::sysctl_val_t syscfg;
	int                     seed;

	always #10 clk_sys = ~clk_sys;

	pc_io_hub dut0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_do     (io_do),
		.io_req    (io_req),
		.io_busy   (io_busy),
		.io_done   (io_done),
		.io_rdata  (io_rdata),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_size  (bus_size),
		.bus_read  (bus_read),
		.bus_write (bus_write),
		.dev_sel   (dev_sel),
		.dev_rdata (dev_rdata),
		.syscfg    (syscfg)
	);

	`include "tb_pc_io_tasks.svh"

	// device models, each group answers only when selected
	always_comb begin
		dev_rdata = '0;
		if (dev_sel.floppy)
			dev_rdata.floppy = group_byte(4'h1, bus_addr);
		if (dev_sel.dma_master || dev_sel.dma_slave || dev_sel.dma_page)
			dev_rdata.dma = group_byte(4'h2, bus_addr);
		if (dev_sel.pic_master || dev_sel.pic_slave)
			dev_rdata.pic = group_byte(4'h3, bus_addr);
		if (dev_sel.pit)
			dev_rdata.pit = group_byte(4'h4, bus_addr);
		if (dev_sel.ps2_io || dev_sel.ps2_ctl)
			dev_rdata.ps2 = group_byte(4'h5, bus_addr);
		if (dev_sel.rtc)
			dev_rdata.rtc = group_byte(4'h6, bus_addr);
		if (dev_sel.sb || dev_sel.fm)
			dev_rdata.sound = group_byte(4'h7, bus_addr);
		if (dev_sel.uart || dev_sel.mpu)
			dev_rdata.uart = group_byte(4'h8, bus_addr);
		if (dev_sel.vga_b || dev_sel.vga_c || dev_sel.vga_d)
			dev_rdata.vga = group_byte(4'h9, bus_addr);
		if (dev_sel.joy)
			dev_rdata.joy = group_byte(4'hA, bus_addr);
		if (dev_sel.hdd0)
			dev_rdata.hdd0 = hdd_word(8'hD0, bus_addr);
		if (dev_sel.hdd1)
			dev_rdata.hdd1 = hdd_word(8'hD1, bus_addr);
	end

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		io_do   = 1'b0;
		io_req  = '0;
		seed    = 32'hdb3b_94d4;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;

		check_reset_state();
		test_sysctl();
		test_device_reads();
		test_open_bus();
		test_timing();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+testbench
design/pc_io_pkg.sv
design/io_port_decoder.sv
design/io_cycle_sequencer.sv
design/io_readback_select.sv
design/sysctl_port.sv
design/pc_io_hub.sv
testbench/tb_pc_io_hub.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pc_io_hub
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := testbench/tb_pc_io_tasks.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
